// ==== cu_control.sv ====
`timescale 1ns/10ps

module cu_control (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  logic                           wed_valid,
	input  logic                           read_alfull,
	input  logic                           response_valid,
	input  logic                           data_valid,
	input  logic                           vertex_cmd_valid,
	input  logic                           graph_cmd_valid,
	input  logic                           vertex_in_valid,
	input  logic [cu_pkg::VERTEX_BITS-1:0] num_vertices,
	input  logic [cu_pkg::VERTEX_BITS-1:0] vertex_done_count,
	input  logic [cu_pkg::EDGE_BITS-1:0]   num_edges,
	input  logic [cu_pkg::EDGE_BITS-1:0]   edge_done_count,
	input  logic [cu_pkg::CONFIG_BITS-1:0] cu_configure,
	input  cu_pkg::response_t              response,
	input  cu_pkg::data_t                  data,
	input  cu_pkg::command_t               vertex_cmd,
	input  cu_pkg::command_t               graph_cmd,
	input  cu_pkg::vertex_t                vertex_in,
	output logic [cu_pkg::CONFIG_BITS-1:0] cu_status,
	output logic [cu_pkg::VERTEX_BITS-1:0] cu_return_vertices,
	output logic [cu_pkg::EDGE_BITS-1:0]   cu_return_edges,
	output logic                           cu_done,
	output logic                           response_vertex_valid,
	output logic                           response_graph_valid,
	output cu_pkg::response_t              response_out,
	output logic                           data_vertex_valid,
	output logic                           data_graph_valid,
	output cu_pkg::data_t                  data_out,
	output logic                           vertex_cmd_grant,
	output logic                           graph_cmd_grant,
	output logic                           read_cmd_valid,
	output cu_pkg::command_t               read_cmd,
	output logic                           vertex_out_valid,
	output cu_pkg::vertex_t                vertex_out
);
	import cu_pkg::*;

	logic                   enabled;
	logic                   run;
	logic                   cu_ready;
	logic                   wed_valid_q;
	logic [CONFIG_BITS-1:0] configure_q;
	logic [VERTEX_BITS-1:0] num_vertices_q;
	logic [EDGE_BITS-1:0]   num_edges_q;
	logic [VERTEX_BITS-1:0] filtered_count;

	////////////////////////////////////////
	// enable, configuration and descriptor
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			run            <= 1'b0;
			wed_valid_q    <= 1'b0;
			configure_q    <= '0;
			num_vertices_q <= '0;
			num_edges_q    <= '0;
			cu_status      <= '0;
		end else begin
			enabled   <= enabled_in;
			run       <= cu_ready;
			cu_status <= configure_q;
			if (enabled) begin
				// a zero word means no new configuration, keep the old one
				if (|cu_configure) begin
					configure_q <= cu_configure;
				end
				wed_valid_q    <= wed_valid;
				num_vertices_q <= num_vertices;
				num_edges_q    <= num_edges;
			end
		end
	end

	assign cu_ready = (|configure_q) && wed_valid_q;

	////////////////////////////////////////
	// units
	////////////////////////////////////////

	cu_response_steer #(.payload_t(response_t)) response_steer (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.in_valid    (response_valid),
		.in_payload  (response),
		.vertex_valid(response_vertex_valid),
		.graph_valid (response_graph_valid),
		.out_payload (response_out)
	);

	cu_response_steer #(.payload_t(data_t)) data_steer (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.in_valid    (data_valid),
		.in_payload  (data),
		.vertex_valid(data_vertex_valid),
		.graph_valid (data_graph_valid),
		.out_payload (data_out)
	);

	cu_read_arbiter read_arbiter (
		.clock           (clock),
		.rstn            (rstn),
		.run             (run),
		.read_alfull     (read_alfull),
		.vertex_cmd_valid(vertex_cmd_valid),
		.graph_cmd_valid (graph_cmd_valid),
		.vertex_cmd      (vertex_cmd),
		.graph_cmd       (graph_cmd),
		.vertex_cmd_grant(vertex_cmd_grant),
		.graph_cmd_grant (graph_cmd_grant),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd        (read_cmd)
	);

	cu_vertex_filter vertex_filter (
		.clock           (clock),
		.rstn            (rstn),
		.run             (run),
		.vertex_in_valid (vertex_in_valid),
		.vertex_in       (vertex_in),
		.vertex_out_valid(vertex_out_valid),
		.vertex_out      (vertex_out),
		.filtered_count  (filtered_count)
	);

	cu_done_tracker done_tracker (
		.clock             (clock),
		.rstn              (rstn),
		.run               (run),
		.num_vertices      (num_vertices_q),
		.vertex_done_count (vertex_done_count),
		.filtered_count    (filtered_count),
		.num_edges         (num_edges_q),
		.edge_done_count   (edge_done_count),
		.cu_return_vertices(cu_return_vertices),
		.cu_return_edges   (cu_return_edges),
		.cu_done           (cu_done)
	);

endmodule

// ==== cu_control_tb.sv ====
`timescale 1ns/10ps

module cu_control_tb;
	import cu_pkg::*;

	localparam int IDLE_CYCLES   = 8;
	localparam int START_CYCLES  = 10;
	localparam int STREAM_CYCLES = 40;
	localparam int CMDS_PER_SIDE = 8;
	localparam int ARB_LIMIT     = 80;
	localparam int DONE_CYCLES   = 24;
	localparam int TOTAL_CYCLES  = IDLE_CYCLES + START_CYCLES + STREAM_CYCLES + ARB_LIMIT
		+ DONE_CYCLES + 20;
	localparam int TIMEOUT_NS    = TOTAL_CYCLES * 10 + 500;

	logic                   clock = 1'b0;
	logic                   rstn;
	logic                   enabled_in, wed_valid, read_alfull;
	logic                   response_valid, data_valid;
	logic                   vertex_cmd_valid, graph_cmd_valid, vertex_in_valid;
	logic [VERTEX_BITS-1:0] num_vertices, vertex_done_count;
	logic [EDGE_BITS-1:0]   num_edges, edge_done_count;
	logic [CONFIG_BITS-1:0] cu_configure;
	response_t              response;
	data_t                  data;
	command_t               vertex_cmd, graph_cmd;
	vertex_t                vertex_in;
	logic [CONFIG_BITS-1:0] cu_status;
	logic [VERTEX_BITS-1:0] cu_return_vertices;
	logic [EDGE_BITS-1:0]   cu_return_edges;
	logic                   cu_done;
	logic                   response_vertex_valid, response_graph_valid;
	response_t              response_out;
	logic                   data_vertex_valid, data_graph_valid;
	data_t                  data_out;
	logic                   vertex_cmd_grant, graph_cmd_grant, read_cmd_valid;
	command_t               read_cmd;
	logic                   vertex_out_valid;
	vertex_t                vertex_out;

	integer seed = 32'h217e_4053;
	integer errors = 0;
	integer checks = 0;
	integer cycle_count = 0;
	integer drops = 0;
	logic   last_granted_graph = 1'b0;
	logic   exp_side;
	logic [CONFIG_BITS-1:0] config_word;

	// expected outputs, with the cycle in which each must show
	response_t exp_resp[$];
	logic      exp_resp_side[$];
	integer    exp_resp_cycle[$];
	data_t     exp_data[$];
	logic      exp_data_side[$];
	integer    exp_data_cycle[$];
	command_t  exp_cmd[$];
	integer    exp_cmd_cycle[$];
	vertex_t   exp_vtx[$];
	integer    exp_vtx_cycle[$];

	cu_control UUT (.*);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cu_count_step: cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// only the vertex control id goes to the vertex job side
	function automatic logic steer_to_vertex(input logic [CU_ID_BITS-1:0] cu_id);
		return cu_id == VERTEX_CONTROL_ID;
	endfunction

	function automatic logic keep_vertex(input vertex_t v);
		return v.in_degree != 0;
	endfunction

	// dropped vertices count as processed
	function automatic logic expected_done(input logic [31:0] vdone, input logic [31:0] dropped,
		input logic [31:0] edone, input logic [31:0] nv, input logic [31:0] ne);
		return (vdone + dropped == nv) && (edone == ne);
	endfunction

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	function automatic logic [CU_ID_BITS-1:0] random_id();
		logic [31:0] r;
		r = random_word();
		return r[0] ? VERTEX_CONTROL_ID : r[15:8];
	endfunction

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		checks = checks + 1;
		if (got !== expected) begin
			errors = errors + 1;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic report_failure(input string what);
		errors = errors + 1;
		$display("at %0t: %s", $time, what);
	endtask

	// registered outputs are stable one ns after the falling edge
	always begin
		@(negedge clock);
		#1;
		if (rstn) begin
			if (response_vertex_valid || response_graph_valid) begin
				if (exp_resp.size() == 0) begin
					report_failure("a response came out that was never driven");
				end else begin
					exp_side = exp_resp_side.pop_front();
					check_value("response_vertex_valid", response_vertex_valid, exp_side);
					check_value("response_graph_valid", response_graph_valid, !exp_side);
					check_value("response_out", response_out, exp_resp.pop_front());
					check_value("response cycle", cycle_count, exp_resp_cycle.pop_front());
				end
			end
			if (data_vertex_valid || data_graph_valid) begin
				if (exp_data.size() == 0) begin
					report_failure("a data beat came out that was never driven");
				end else begin
					exp_side = exp_data_side.pop_front();
					check_value("data_vertex_valid", data_vertex_valid, exp_side);
					check_value("data_graph_valid", data_graph_valid, !exp_side);
					check_value("data_out", data_out, exp_data.pop_front());
					check_value("data cycle", cycle_count, exp_data_cycle.pop_front());
				end
			end
			if (read_cmd_valid) begin
				if (exp_cmd.size() == 0) begin
					report_failure("a read command came out without a grant");
				end else begin
					check_value("read_cmd", read_cmd, exp_cmd.pop_front());
					check_value("read_cmd cycle", cycle_count, exp_cmd_cycle.pop_front());
				end
			end
			if (vertex_out_valid) begin
				if (exp_vtx.size() == 0) begin
					report_failure("a vertex was forwarded that should have been dropped");
				end else begin
					check_value("vertex_out", vertex_out, exp_vtx.pop_front());
					check_value("vertex_out cycle", cycle_count, exp_vtx_cycle.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////
	// test phases
	////////////////////////////////////////

	// random strobes while disabled must not get through
	task automatic check_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clock);
			response_valid   = random_word() & 1;
			data_valid       = random_word() & 1;
			vertex_cmd_valid = random_word() & 1;
			graph_cmd_valid  = random_word() & 1;
			vertex_in_valid  = random_word() & 1;
			#2;
			check_value("response_vertex_valid", response_vertex_valid, 0);
			check_value("response_graph_valid", response_graph_valid, 0);
			check_value("data_vertex_valid", data_vertex_valid, 0);
			check_value("data_graph_valid", data_graph_valid, 0);
			check_value("vertex_cmd_grant", vertex_cmd_grant, 0);
			check_value("graph_cmd_grant", graph_cmd_grant, 0);
			check_value("read_cmd_valid", read_cmd_valid, 0);
			check_value("vertex_out_valid", vertex_out_valid, 0);
			check_value("cu_done", cu_done, 0);
			check_value("cu_return_vertices", cu_return_vertices, 0);
			check_value("cu_return_edges", cu_return_edges, 0);
			check_value("cu_status", cu_status, 0);
		end
	endtask

	task automatic start_unit();
		@(negedge clock);
		response_valid   = 1'b0;
		data_valid       = 1'b0;
		vertex_cmd_valid = 1'b0;
		graph_cmd_valid  = 1'b0;
		vertex_in_valid  = 1'b0;
		config_word      = {random_word(), random_word()} | 64'h1;
		enabled_in       = 1'b1;
		wed_valid        = 1'b1;
		cu_configure     = config_word;
		num_vertices     = 64;
		num_edges        = random_word();
		repeat (5) @(negedge clock);
		#1;
		check_value("cu_status", cu_status, config_word);
		// a zero word is no new configuration
		cu_configure = '0;
		repeat (4) @(negedge clock);
		#1;
		check_value("cu_status", cu_status, config_word);
	endtask

	task automatic drive_streams(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			@(negedge clock);
			r = random_word();
			response_valid  = r[0];
			data_valid      = r[1];
			vertex_in_valid = r[2];
			response.cu_id  = random_id();
			response.tag    = random_word();
			data.cu_id      = random_id();
			data.data       = {random_word(), random_word()};
			vertex_in.id         = i;
			vertex_in.in_degree  = (r[5:4] == 0) ? '0 : random_word();
			vertex_in.out_degree = random_word();
			if (response_valid) begin
				exp_resp.push_back(response);
				exp_resp_side.push_back(steer_to_vertex(response.cu_id));
				exp_resp_cycle.push_back(cycle_count + 2);
			end
			if (data_valid) begin
				exp_data.push_back(data);
				exp_data_side.push_back(steer_to_vertex(data.cu_id));
				exp_data_cycle.push_back(cycle_count + 2);
			end
			if (vertex_in_valid && keep_vertex(vertex_in)) begin
				exp_vtx.push_back(vertex_in);
				exp_vtx_cycle.push_back(cycle_count + 1);
			end else if (vertex_in_valid) begin
				drops = drops + 1;
			end
		end
		@(negedge clock);
		response_valid  = 1'b0;
		data_valid      = 1'b0;
		vertex_in_valid = 1'b0;
		repeat (4) @(negedge clock);
	endtask

	// the testbench holds each command until its grant, as a requester would
	task automatic run_arbitration();
		command_t vq[$];
		command_t gq[$];
		command_t c;
		logic     exp_vgrant;
		logic     exp_ggrant;
		int       cycles;
		for (int i = 0; i < CMDS_PER_SIDE; i++) begin
			c = {random_word(), random_word(), random_word()};
			vq.push_back(c);
			c = {random_word(), random_word(), random_word()};
			gq.push_back(c);
		end
		cycles = 0;
		while (vq.size() != 0 || gq.size() != 0) begin
			@(negedge clock);
			vertex_cmd_valid = vq.size() != 0;
			graph_cmd_valid  = gq.size() != 0;
			if (vertex_cmd_valid) vertex_cmd = vq[0];
			if (graph_cmd_valid) graph_cmd = gq[0];
			read_alfull = (random_word() & 3) == 0;
			#2;
			exp_vgrant = 1'b0;
			exp_ggrant = 1'b0;
			if (!read_alfull && vertex_cmd_valid && graph_cmd_valid) begin
				exp_vgrant = last_granted_graph;
				exp_ggrant = !last_granted_graph;
			end else if (!read_alfull) begin
				exp_vgrant = vertex_cmd_valid;
				exp_ggrant = graph_cmd_valid;
			end
			check_value("vertex_cmd_grant", vertex_cmd_grant, exp_vgrant);
			check_value("graph_cmd_grant", graph_cmd_grant, exp_ggrant);
			if (vertex_cmd_grant && vq.size() != 0) begin
				exp_cmd.push_back(vq.pop_front());
				exp_cmd_cycle.push_back(cycle_count + 1);
				last_granted_graph = 1'b0;
			end else if (graph_cmd_grant && gq.size() != 0) begin
				exp_cmd.push_back(gq.pop_front());
				exp_cmd_cycle.push_back(cycle_count + 1);
				last_granted_graph = 1'b1;
			end
			cycles = cycles + 1;
			if (cycles > ARB_LIMIT) begin
				report_failure("the read arbiter stopped granting held commands");
				break;
			end
		end
		@(negedge clock);
		vertex_cmd_valid = 1'b0;
		graph_cmd_valid  = 1'b0;
		read_alfull      = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	task automatic check_done(input logic [31:0] vdone, input logic [31:0] edone);
		@(negedge clock);
		vertex_done_count = vdone;
		edge_done_count   = edone;
		repeat (5) @(negedge clock);
		#1;
		check_value("cu_return_vertices", cu_return_vertices, vdone + drops);
		check_value("cu_return_edges", cu_return_edges, edone);
		check_value("cu_done", cu_done,
			expected_done(vdone, drops, edone, num_vertices, num_edges));
	endtask

	task automatic check_drained();
		if (exp_resp.size() != 0) report_failure("some responses never came out");
		if (exp_data.size() != 0) report_failure("some data beats never came out");
		if (exp_cmd.size() != 0) report_failure("some granted commands never came out");
		if (exp_vtx.size() != 0) report_failure("some kept vertices were never forwarded");
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		rstn              = 1'b0;
		enabled_in        = 1'b0;
		wed_valid         = 1'b0;
		read_alfull       = 1'b0;
		response_valid    = 1'b0;
		data_valid        = 1'b0;
		vertex_cmd_valid  = 1'b0;
		graph_cmd_valid   = 1'b0;
		vertex_in_valid   = 1'b0;
		num_vertices      = '0;
		vertex_done_count = '0;
		num_edges         = '0;
		edge_done_count   = '0;
		cu_configure      = '0;
		response          = '0;
		data              = '0;
		vertex_cmd        = '0;
		graph_cmd         = '0;
		vertex_in         = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		check_idle(IDLE_CYCLES);
		start_unit();
		drive_streams(STREAM_CYCLES);
		run_arbitration();
		check_done(num_vertices - drops - 1, num_edges);
		check_done(num_vertices - drops, num_edges - 1);
		check_done(num_vertices - drops, num_edges);
		repeat (4) @(negedge clock);
		check_drained();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not end within %0d ns", TIMEOUT_NS);
		$display("%0d checks, %0d errors", checks, errors + 1);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== cu_done_tracker.sv ====
`timescale 1ns/10ps

module cu_done_tracker (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           run,
	input  logic [cu_pkg::VERTEX_BITS-1:0] num_vertices,
	input  logic [cu_pkg::VERTEX_BITS-1:0] vertex_done_count,
	input  logic [cu_pkg::VERTEX_BITS-1:0] filtered_count,
	input  logic [cu_pkg::EDGE_BITS-1:0]   num_edges,
	input  logic [cu_pkg::EDGE_BITS-1:0]   edge_done_count,
	output logic [cu_pkg::VERTEX_BITS-1:0] cu_return_vertices,
	output logic [cu_pkg::EDGE_BITS-1:0]   cu_return_edges,
	output logic                           cu_done
);
	import cu_pkg::*;

	logic [VERTEX_BITS-1:0] vertex_done_q;
	logic [EDGE_BITS-1:0]   edge_done_q;
	logic [VERTEX_BITS-1:0] vertex_total;
	logic [EDGE_BITS-1:0]   edge_total;
	logic [VERTEX_BITS-1:0] vertex_ret;
	logic [EDGE_BITS-1:0]   edge_ret;
	logic                   vertices_match;
	logic                   edges_match;

	////////////////////////////////////////
	// four stage pipeline, frozen while idle
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_q      <= '0;
			edge_done_q        <= '0;
			vertex_total       <= '0;
			edge_total         <= '0;
			vertex_ret         <= '0;
			edge_ret           <= '0;
			vertices_match     <= 1'b0;
			edges_match        <= 1'b0;
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_done            <= 1'b0;
		end else if (run) begin
			// stage 1: sample the running counts
			vertex_done_q <= vertex_done_count;
			edge_done_q   <= edge_done_count;
			// stage 2: dropped vertices count as processed
			vertex_total <= vertex_done_q + filtered_count;
			edge_total   <= edge_done_q;
			// stage 3: compare against the descriptor
			vertices_match <= (vertex_total == num_vertices);
			edges_match    <= (edge_total == num_edges);
			vertex_ret     <= vertex_total;
			edge_ret       <= edge_total;
			// stage 4
			cu_return_vertices <= vertex_ret;
			cu_return_edges    <= edge_ret;
			cu_done            <= vertices_match && edges_match;
		end
	end

endmodule

// ==== cu_pkg.sv ====
package cu_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int CU_ID_BITS  = 8;
	localparam int VERTEX_BITS = 32;
	localparam int EDGE_BITS   = 32;
	localparam int CONFIG_BITS = 64;
	localparam int ADDR_BITS   = 64;
	localparam int DATA_BITS   = 64;
	localparam int TAG_BITS    = 16;
	localparam int SIZE_BITS   = 16;

	// tag id owned by the vertex job reader, everything else is graph side
	localparam logic [CU_ID_BITS-1:0] VERTEX_CONTROL_ID = 8'h80;

	////////////////////////////////////////
	// payloads
	////////////////////////////////////////

	typedef struct packed {
		logic [CU_ID_BITS-1:0] cu_id;
		logic [TAG_BITS-1:0]   tag;
	} response_t;

	typedef struct packed {
		logic [CU_ID_BITS-1:0] cu_id;
		logic [DATA_BITS-1:0]  data;
	} data_t;

	typedef struct packed {
		logic [CU_ID_BITS-1:0] cu_id;
		logic [ADDR_BITS-1:0]  address;
		logic [SIZE_BITS-1:0]  size;
	} command_t;

	// in_degree counts edges pointing at the vertex
	typedef struct packed {
		logic [VERTEX_BITS-1:0] id;
		logic [VERTEX_BITS-1:0] in_degree;
		logic [VERTEX_BITS-1:0] out_degree;
	} vertex_t;

endpackage

// ==== cu_read_arbiter.sv ====
`timescale 1ns/10ps

module cu_read_arbiter (
	input  logic             clock,
	input  logic             rstn,
	input  logic             run,
	input  logic             read_alfull,
	input  logic             vertex_cmd_valid,
	input  logic             graph_cmd_valid,
	input  cu_pkg::command_t vertex_cmd,
	input  cu_pkg::command_t graph_cmd,
	output logic             vertex_cmd_grant,
	output logic             graph_cmd_grant,
	output logic             read_cmd_valid,
	output cu_pkg::command_t read_cmd
);
	import cu_pkg::*;

	logic     last_graph;
	logic     grant_ok;
	logic     pick_graph;
	command_t chosen_cmd;

	////////////////////////////////////////
	// grant
	////////////////////////////////////////

	// no grant while the read buffer is close to full, requests stay held
	assign grant_ok = run && !read_alfull;

	// graph wins when alone, or on a tie when vertex went last
	assign pick_graph = graph_cmd_valid && (!vertex_cmd_valid || !last_graph);

	assign vertex_cmd_grant = grant_ok && vertex_cmd_valid && !pick_graph;
	assign graph_cmd_grant  = grant_ok && pick_graph;

	assign chosen_cmd = pick_graph ? graph_cmd : vertex_cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_graph <= 1'b0;
		end else if (vertex_cmd_grant || graph_cmd_grant) begin
			last_graph <= graph_cmd_grant;
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
		end else begin
			read_cmd_valid <= vertex_cmd_grant || graph_cmd_grant;
		end
	end

	always_ff @(posedge clock) begin
		read_cmd <= chosen_cmd;
	end

	a_grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0({vertex_cmd_grant, graph_cmd_grant}));

	a_alfull_hold: assert property (@(posedge clock) disable iff (!rstn)
		read_alfull |-> !(vertex_cmd_grant || graph_cmd_grant));

endmodule

// ==== cu_response_steer.sv ====
`timescale 1ns/10ps

module cu_response_steer #(
	parameter type payload_t = cu_pkg::response_t
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     vertex_valid,
	output logic     graph_valid,
	output payload_t out_payload
);
	import cu_pkg::*;

	logic     in_valid_q;
	payload_t in_payload_q;
	logic     to_vertex;

	////////////////////////////////////////
	// stage 1: input latch
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= enabled && in_valid;
		end
	end

	always_ff @(posedge clock) begin
		in_payload_q <= in_payload;
	end

	////////////////////////////////////////
	// stage 2: route by compute-unit id
	////////////////////////////////////////

	assign to_vertex = (in_payload_q.cu_id == VERTEX_CONTROL_ID);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid <= 1'b0;
			graph_valid  <= 1'b0;
		end else begin
			vertex_valid <= in_valid_q && to_vertex;
			graph_valid  <= in_valid_q && !to_vertex;
		end
	end

	// payload goes to both sides, the valids pick the owner
	always_ff @(posedge clock) begin
		out_payload <= in_payload_q;
	end

	a_one_side: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_valid && graph_valid));

endmodule

// ==== cu_vertex_filter.sv ====
`timescale 1ns/10ps

module cu_vertex_filter (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           run,
	input  logic                           vertex_in_valid,
	input  cu_pkg::vertex_t                vertex_in,
	output logic                           vertex_out_valid,
	output cu_pkg::vertex_t                vertex_out,
	output logic [cu_pkg::VERTEX_BITS-1:0] filtered_count
);

	logic accept;
	logic keep;

	assign accept = run && vertex_in_valid;

	// a vertex nobody points at has no work to do
	assign keep = |vertex_in.in_degree;

	////////////////////////////////////////
	// forward or drop
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_out_valid <= 1'b0;
			filtered_count   <= '0;
		end else begin
			vertex_out_valid <= accept && keep;
			if (accept && !keep) begin
				filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		vertex_out <= vertex_in;
	end

	a_no_zero_forward: assert property (@(posedge clock) disable iff (!rstn)
		vertex_out_valid |-> (vertex_out.in_degree != '0));

endmodule

// ==== verilog.f ====
cu_pkg.sv
cu_response_steer.sv
cu_read_arbiter.sv
cu_vertex_filter.sv
cu_done_tracker.sv
cu_control.sv
cu_control_tb.sv
